//--- tb.f
hdl/rv_decode_pkg.sv
hdl/fetch_bundle_if.sv
hdl/if_id_barrier.sv
hdl/reg_file.sv
hdl/insn_classifier.sv
hdl/branch_decoder.sv
hdl/id_stage.sv
tests/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - files:
      - hdl/rv_decode_pkg.sv
      - hdl/fetch_bundle_if.sv
      - hdl/if_id_barrier.sv
      - hdl/reg_file.sv
      - hdl/insn_classifier.sv
      - hdl/branch_decoder.sv
      - hdl/id_stage.sv
  - target: test
    files:
      - tests/tb_id_stage.sv

//--- tests/tb_id_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RV32 instruction-decode stage.
// LFSR stimulus, reference model of the barrier and register file,
// legality and branch rules, concurrent checks and the closing report.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_id_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] LFSR_SEED  = 32'he55a_c0e4;
    localparam int          WAIT_LIMIT = 8;
    localparam logic [31:0] MRET_WORD  = 32'h3020_0073;

    logic clk = 1'b0;
    logic rst, d_valid, d_trap, stall, clear, fw_rs1_bt, wb_we;
    logic q_valid, q_use_rd, q_branch, q_branch_predict, q_trap;
    logic is_mret, is_jump, is_branch, branch_predict, use_rs1_bt;
    rv_decode_pkg::pc_t      d_pc, q_pc, branch_target;
    rv_decode_pkg::insn_t    d_insn, q_insn;
    rv_decode_pkg::cause_t   d_cause, q_cause;
    rv_decode_pkg::reg_idx_t wb_rd;
    rv_decode_pkg::word_t    wb_wdata, fw_val, q_rs1_val, q_rs2_val;

    // Reference copy of the barrier contents and the registers.
    logic                  mdl_valid, mdl_trap;
    rv_decode_pkg::pc_t    mdl_pc;
    rv_decode_pkg::insn_t  mdl_insn;
    rv_decode_pkg::cause_t mdl_cause;
    rv_decode_pkg::word_t  shadow [0:31];

    logic                 legal, exp_valid, exp_trap, exp_jump, exp_branch;
    rv_decode_pkg::word_t jalr_base;
    rv_decode_pkg::pc_t   exp_target;

    logic [31:0] lfsr = LFSR_SEED;
    int errors   = 0;
    int timeouts = 0;
    int issued   = 0;

    logic [31:0] targeted [0:16] = '{
        32'h0220_81b3, 32'h0220_c1b3, 32'h3000_10f3, 32'h3000_4073, MRET_WORD,
        32'h0000_0073, 32'h0010_0073, 32'h1050_0073, 32'h3020_00f3, 32'h4000_1093,
        32'h4030_5093, 32'h6030_5093, 32'h4020_81b3, 32'h4020_91b3, 32'h0000_0001,
        32'h0000_3003, 32'h0000_3023
    };

    id_stage #(.HAS_M(1'b1), .HAS_ZICSR(1'b1)) uut (.*);

    always #10 clk = ~clk;

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic is_legal(input rv_decode_pkg::insn_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        if (w[1:0] != 2'b11) begin
            return 1'b0;
        end
        case (w[6:2])
            rv_decode_pkg::LUI, rv_decode_pkg::AUIPC, rv_decode_pkg::JAL: return 1'b1;
            rv_decode_pkg::JALR:     return f3 == 3'd0;
            rv_decode_pkg::BRANCH:   return f3 != 3'd2 && f3 != 3'd3;
            rv_decode_pkg::LOAD:     return f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            rv_decode_pkg::STORE:    return f3 <= 3'd2;
            rv_decode_pkg::MISC_MEM: return f3 <= 3'd1;
            rv_decode_pkg::OP_IMM:   return (f3 == 3'd1) ? (f7 == 7'h00)
                                          : (f3 == 3'd5) ? (f7 inside {7'h00, 7'h20}) : 1'b1;
            rv_decode_pkg::OP:       return f7 == 7'h00 || f7 == 7'h01
                                          || (f7 == 7'h20 && f3 inside {3'd0, 3'd5});
            // ECALL, EBREAK, MRET and WFI only, else CSR access.
            rv_decode_pkg::SYSTEM:   return (f3 == 3'd0)
                ? (w inside {32'h0000_0073, 32'h0010_0073, MRET_WORD, 32'h1050_0073})
                : (f3 != 3'd4);
            default:                 return 1'b0;
        endcase
    endfunction

    function automatic logic writes_rd(input rv_decode_pkg::insn_t w);
        if (w[6:2] == rv_decode_pkg::SYSTEM) begin
            return w[14:12] != 3'd0;
        end
        return w[6:2] inside {rv_decode_pkg::LOAD, rv_decode_pkg::OP_IMM, rv_decode_pkg::AUIPC,
                              rv_decode_pkg::OP, rv_decode_pkg::LUI, rv_decode_pkg::JAL,
                              rv_decode_pkg::JALR};
    endfunction

    function automatic rv_decode_pkg::pc_t flow_target(input rv_decode_pkg::insn_t w,
                                                       input rv_decode_pkg::pc_t pc,
                                                       input rv_decode_pkg::word_t rs1);
        rv_decode_pkg::word_t sum;
        case (w[6:2])
            rv_decode_pkg::JAL:  sum = {pc, 1'b0}
                + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            rv_decode_pkg::JALR: sum = rs1 + {{20{w[31]}}, w[31:20]};
            default:             sum = {pc, 1'b0}
                + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        endcase
        return sum[31:1];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            mdl_valid <= 1'b0;
            mdl_trap  <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (!stall) begin
                mdl_valid <= d_valid;
                mdl_trap  <= d_trap;
            end
            if (wb_we && wb_rd != 5'd0) begin
                shadow[wb_rd] <= wb_wdata;
            end
        end
        if (!stall) begin
            mdl_pc    <= d_pc;
            mdl_insn  <= d_insn;
            mdl_cause <= d_cause;
        end
    end

    always_comb begin
        legal      = is_legal(mdl_insn);
        exp_valid  = !clear && mdl_valid && !mdl_trap && legal;
        exp_trap   = !clear && (mdl_trap || (mdl_valid && !legal));
        exp_jump   = mdl_insn[6:2] inside {rv_decode_pkg::JAL, rv_decode_pkg::JALR};
        exp_branch = mdl_insn[6:2] == rv_decode_pkg::BRANCH;
        jalr_base  = fw_rs1_bt ? fw_val : shadow[mdl_insn[19:15]];
        exp_target = flow_target(mdl_insn, mdl_pc, jalr_base);
    end

    task automatic log_mismatch(input string what);
        errors++;
        $display("error at %0d ns: %s", $time, what);
    endtask

    assert property (@(posedge clk) $fell(rst) |-> !q_valid && !q_trap)
        else log_mismatch("q_valid or q_trap high right after reset");
    assert property (@(posedge clk) disable iff (rst) q_valid == exp_valid)
        else log_mismatch("q_valid differs from the legality rules");
    assert property (@(posedge clk) disable iff (rst) q_trap == exp_trap)
        else log_mismatch("q_trap differs from the legality rules");
    assert property (@(posedge clk) disable iff (rst) mdl_valid && !clear |-> q_valid != q_trap)
        else log_mismatch("valid input gave not exactly one of q_valid and q_trap");
    assert property (@(posedge clk) disable iff (rst) clear |-> !q_valid && !q_trap)
        else log_mismatch("clear did not suppress the outputs");
    assert property (@(posedge clk) disable iff (rst)
        exp_trap |-> q_cause == (mdl_trap ? mdl_cause : 4'd2))
        else log_mismatch("q_cause wrong");
    assert property (@(posedge clk) disable iff (rst) stall |=> $stable(q_pc) && $stable(q_insn))
        else log_mismatch("q_pc or q_insn changed during stall");
    assert property (@(posedge clk) disable iff (rst)
        mdl_valid |-> q_pc == mdl_pc && q_insn == mdl_insn && q_use_rd == writes_rd(mdl_insn))
        else log_mismatch("q_pc, q_insn or q_use_rd wrong");
    assert property (@(posedge clk) disable iff (rst) mdl_valid |->
        q_rs1_val == shadow[mdl_insn[19:15]] && q_rs2_val == shadow[mdl_insn[24:20]])
        else log_mismatch("register read differs from shadow copy");
    assert property (@(posedge clk) disable iff (rst) mdl_valid |->
        is_jump == exp_jump && is_branch == exp_branch && q_branch == exp_branch
        && use_rs1_bt == (mdl_insn[6:2] == rv_decode_pkg::JALR)
        && is_mret == (mdl_insn == MRET_WORD)
        && branch_predict == mdl_insn[31] && q_branch_predict == mdl_insn[31])
        else log_mismatch("control-flow flags wrong");
    assert property (@(posedge clk) disable iff (rst)
        mdl_valid && (exp_jump || exp_branch) |-> branch_target == exp_target)
        else log_mismatch("branch_target wrong");

    // Write-back traffic and JALR forwarding beside each instruction.
    task automatic drive_side();
        wb_we     = 1'(next_bits(1));
        wb_rd     = 5'(next_bits(5));
        wb_wdata  = next_bits(32);
        fw_rs1_bt = 1'(next_bits(1));
        fw_val    = next_bits(32);
    endtask

    task automatic await_outcome();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(q_valid || q_trap) && n < WAIT_LIMIT);
        if (!(q_valid || q_trap)) begin
            timeouts++;
            $display("timeout: no decode result within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic issue(input logic valid, input rv_decode_pkg::insn_t w,
                         input logic trap, input rv_decode_pkg::cause_t cause);
        @(negedge clk);
        d_valid = valid;
        d_pc    = 31'(next_bits(31));
        d_insn  = w;
        d_trap  = trap;
        d_cause = cause;
        drive_side();
        issued++;
        if ((valid || trap) && !clear && !stall) begin
            await_outcome();
        end
    endtask

    initial begin
        logic [31:0] r;
        // Fetch already presents a live word and a trap while reset is held.
        rst       = 1'b1;
        d_valid   = 1'b1;
        d_pc      = '0;
        d_insn    = '0;
        d_trap    = 1'b1;
        d_cause   = '0;
        stall     = 1'b0;
        clear     = 1'b0;
        fw_rs1_bt = 1'b0;
        fw_val    = '0;
        wb_we     = 1'b0;
        wb_rd     = '0;
        wb_wdata  = '0;
        repeat (8) @(negedge clk);
        rst     = 1'b0;
        d_valid = 1'b0;
        d_trap  = 1'b0;

        // Fill registers, then read them back with OP instructions.
        for (int i = 0; i < 24; i++) begin
            @(negedge clk);
            wb_we    = 1'b1;
            wb_rd    = 5'(next_bits(5));
            wb_wdata = next_bits(32);
        end
        for (int i = 0; i < 40; i++) begin
            r = next_bits(32);
            issue(1'b1, {7'h00, r[24:15], 3'd0, r[11:7], 7'b0110011}, 1'b0, '0);
        end

        foreach (targeted[i]) begin
            issue(1'b1, targeted[i], 1'b0, '0);
        end
        for (int i = 0; i < 80; i++) begin
            r = next_bits(32);
            if (next_bits(2) != 0) begin
                r[1:0] = 2'b11;
            end
            issue(1'b1, r, 1'b0, '0);
        end

        // JAL, JALR and conditional branches.
        for (int i = 0; i < 60; i++) begin
            r = next_bits(32);
            case (next_bits(2))
                0: r[6:0] = 7'b1101111;
                1: r[14:0] = {3'd0, r[11:7], 7'b1100111};
                default: r[6:0] = 7'b1100011;
            endcase
            issue(1'b1, r, 1'b0, '0);
        end

        for (int i = 0; i < 20; i++) begin
            issue(1'(next_bits(1)), next_bits(32), 1'b1, 4'(next_bits(4)));
        end

        // Hold the stage while fetch keeps changing.
        issue(1'b1, 32'h0010_0093, 1'b0, '0);
        @(negedge clk);
        stall = 1'b1;
        for (int i = 0; i < 6; i++) begin
            issue(1'b1, next_bits(32), 1'(next_bits(1)), 4'(next_bits(4)));
        end
        stall = 1'b0;

        issue(1'b1, 32'h0020_8133, 1'b0, '0);
        @(negedge clk);
        clear = 1'b1;
        for (int i = 0; i < 4; i++) begin
            issue(1'b1, next_bits(32), 1'(next_bits(1)), 4'(next_bits(4)));
        end
        clear = 1'b0;
        repeat (3) @(negedge clk);

        $display("issued %0d, errors %0d, timeouts %0d", issued, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hdl/id_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction-decode stage of the in-order RV32 core.
// IF/ID barrier, register file, legality check, branch decode,
// trap merging and the ID/EX outputs.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module id_stage #(
    parameter bit HAS_M     = 1'b1,
    parameter bit HAS_ZICSR = 1'b1
) (
    input  logic                    clk,
    input  logic                    rst,

    // From fetch.
    input  logic                    d_valid,
    input  rv_decode_pkg::pc_t      d_pc,
    input  rv_decode_pkg::insn_t    d_insn,
    input  logic                    d_trap,
    input  rv_decode_pkg::cause_t   d_cause,

    // To execute.
    output logic                    q_valid,
    output rv_decode_pkg::pc_t      q_pc,
    output rv_decode_pkg::insn_t    q_insn,
    output logic                    q_use_rd,
    output rv_decode_pkg::word_t    q_rs1_val,
    output rv_decode_pkg::word_t    q_rs2_val,
    output logic                    q_branch,
    output logic                    q_branch_predict,
    output logic                    q_trap,
    output rv_decode_pkg::cause_t   q_cause,

    // Fetch redirect.
    output logic                    is_mret,
    output logic                    is_jump,
    output logic                    is_branch,
    output logic                    branch_predict,
    output rv_decode_pkg::pc_t      branch_target,
    output logic                    use_rs1_bt,

    // Write-back.
    input  logic                    wb_we,
    input  rv_decode_pkg::reg_idx_t wb_rd,
    input  rv_decode_pkg::word_t    wb_wdata,

    // Hazard control.
    input  logic                    stall,
    input  logic                    clear,
    input  logic                    fw_rs1_bt,
    input  rv_decode_pkg::word_t    fw_val
);

    fetch_bundle_if fb ();

    rv_decode_pkg::word_t rs1_val;
    rv_decode_pkg::word_t bt_rs1_val;
    logic                 insn_ok;

    if_id_barrier u_barrier (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .d_valid (d_valid),
        .d_pc    (d_pc),
        .d_insn  (d_insn),
        .d_trap  (d_trap),
        .d_cause (d_cause),
        .out     (fb)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .we      (wb_we),
        .wr_idx  (wb_rd),
        .wdata   (wb_wdata),
        .rs1_idx (fb.insn[19:15]),
        .rs2_idx (fb.insn[24:20]),
        .rs1_val (rs1_val),
        .rs2_val (q_rs2_val)
    );

    insn_classifier #(
        .HAS_M     (HAS_M),
        .HAS_ZICSR (HAS_ZICSR)
    ) u_classifier (
        .fb      (fb),
        .insn_ok (insn_ok),
        .use_rd  (q_use_rd)
    );

    // Late rs1 from execute overrides the register file for JALR.
    assign bt_rs1_val = fw_rs1_bt ? fw_val : rs1_val;

    branch_decoder u_branch_decoder (
        .fb        (fb),
        .rs1_val   (bt_rs1_val),
        .is_mret   (is_mret),
        .is_jump   (is_jump),
        .is_branch (is_branch),
        .predict   (branch_predict),
        .use_rs1   (use_rs1_bt),
        .target    (branch_target)
    );

    assign q_pc             = fb.pc;
    assign q_insn           = fb.insn;
    assign q_rs1_val        = rs1_val;
    assign q_branch         = is_branch;
    assign q_branch_predict = branch_predict;

    // An upstream trap takes priority over the illegal-instruction check.
    assign q_valid = !clear && fb.valid && !fb.trap && insn_ok;
    assign q_trap  = !clear && (fb.trap || (fb.valid && !insn_ok));
    assign q_cause = fb.trap ? fb.cause : rv_decode_pkg::CAUSE_ILLEGAL_INSN;

    // Execute sees either an instruction or a trap, never both.
    assert property (@(posedge clk) disable iff (rst)
        !(q_valid && q_trap));

endmodule

//--- hdl/branch_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control-flow classification and target address adder.
// Static prediction, backward branches taken.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module branch_decoder (
    fetch_bundle_if.decode             fb,
    input  rv_decode_pkg::word_t       rs1_val,
    output logic                       is_mret,
    output logic                       is_jump,
    output logic                       is_branch,
    output logic                       predict,
    output logic                       use_rs1,
    output rv_decode_pkg::pc_t         target
);

    rv_decode_pkg::word_t add_lhs;
    rv_decode_pkg::word_t add_rhs;
    rv_decode_pkg::word_t add_res;

    always_comb begin
        is_jump   = 1'b0;
        is_branch = 1'b0;
        use_rs1   = 1'b0;
        add_lhs   = {fb.pc, 1'b0};
        add_rhs   = '0;
        case (rv_decode_pkg::opcode_t'(fb.insn[6:2]))
            rv_decode_pkg::JAL: begin
                is_jump = 1'b1;
                add_rhs = {{12{fb.insn[31]}}, fb.insn[19:12], fb.insn[20],
                           fb.insn[30:21], 1'b0};
            end
            rv_decode_pkg::JALR: begin
                is_jump = 1'b1;
                use_rs1 = 1'b1;
                add_lhs = rs1_val;
                add_rhs = {{20{fb.insn[31]}}, fb.insn[31:20]};
            end
            rv_decode_pkg::BRANCH: begin
                is_branch = 1'b1;
                add_rhs   = {{20{fb.insn[31]}}, fb.insn[7], fb.insn[30:25],
                             fb.insn[11:8], 1'b0};
            end
            default: begin
                add_rhs = '0;
            end
        endcase
    end

    // Bit 0 of the sum is dropped, as JALR requires.
    assign add_res = add_lhs + add_rhs;
    assign target  = add_res[31:1];

    // Sign of the offset.
    assign predict = fb.insn[31];

    assign is_mret = (fb.insn == rv_decode_pkg::INSN_MRET);

    always_comb begin
        assert final (!(is_jump && is_branch));
    end

endmodule

//--- hdl/insn_classifier.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction legality check for RV32I, with optional M and Zicsr.
// Also reports whether the instruction writes rd.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module insn_classifier #(
    parameter bit HAS_M     = 1'b1,
    parameter bit HAS_ZICSR = 1'b1
) (
    fetch_bundle_if.decode fb,
    output logic           insn_ok,
    output logic           use_rd
);

    rv_decode_pkg::opcode_t opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [11:0]            funct12;
    logic                   rule_ok;
    logic                   op_imm_ok;
    logic                   op_ok;
    logic                   priv_ok;

    assign opcode  = rv_decode_pkg::opcode_t'(fb.insn[6:2]);
    assign funct3  = fb.insn[14:12];
    assign funct7  = fb.insn[31:25];
    assign funct12 = fb.insn[31:20];

    // Shift immediates carry funct7 in the upper bits.
    always_comb begin
        if (funct3 == rv_decode_pkg::F3_SLL) begin
            op_imm_ok = (funct7 == 7'b0000000);
        end else if (funct3 == rv_decode_pkg::F3_SRL) begin
            op_imm_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
            op_imm_ok = 1'b1;
        end
    end

    // Register-register ALU and multiply/divide.
    always_comb begin
        case (funct7)
            7'b0000000: op_ok = 1'b1;
            7'b0100000: op_ok = (funct3 == rv_decode_pkg::F3_ADD)
                             || (funct3 == rv_decode_pkg::F3_SRL);
            7'b0000001: op_ok = HAS_M;
            default:    op_ok = 1'b0;
        endcase
    end

    // ECALL, EBREAK, WFI and MRET with rs1 and rd zero.
    always_comb begin
        priv_ok = (fb.insn[19:15] == '0) && (fb.insn[11:7] == '0);
        case (funct12)
            12'h000, 12'h001, 12'h105: priv_ok = priv_ok;
            rv_decode_pkg::INSN_MRET[31:20]: priv_ok = priv_ok;
            default: priv_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_decode_pkg::LUI,
            rv_decode_pkg::AUIPC,
            rv_decode_pkg::JAL:      rule_ok = 1'b1;
            rv_decode_pkg::JALR:     rule_ok = (funct3 == 3'd0);
            rv_decode_pkg::BRANCH:   rule_ok = (funct3 != 3'd2) && (funct3 != 3'd3);
            rv_decode_pkg::LOAD:     rule_ok = (funct3 != 3'd3) && (funct3 < 3'd6);
            rv_decode_pkg::STORE:    rule_ok = (funct3 < 3'd3);
            rv_decode_pkg::MISC_MEM: rule_ok = (funct3 < 3'd2);
            rv_decode_pkg::OP_IMM:   rule_ok = op_imm_ok;
            rv_decode_pkg::OP:       rule_ok = op_ok;
            rv_decode_pkg::SYSTEM: begin
                if (funct3 == 3'd0) begin
                    rule_ok = priv_ok;
                end else begin
                    // CSR access, funct3 4 is reserved.
                    rule_ok = HAS_ZICSR && (funct3 != 3'd4);
                end
            end
            default:                 rule_ok = 1'b0;
        endcase
    end

    // Compressed encodings are not supported.
    assign insn_ok = (fb.insn[1:0] == 2'b11) && rule_ok;

    always_comb begin
        case (opcode)
            rv_decode_pkg::LOAD,
            rv_decode_pkg::OP_IMM,
            rv_decode_pkg::AUIPC,
            rv_decode_pkg::OP,
            rv_decode_pkg::LUI,
            rv_decode_pkg::JAL,
            rv_decode_pkg::JALR:   use_rd = 1'b1;
            rv_decode_pkg::SYSTEM: use_rd = (funct3 != 3'd0);
            default:               use_rd = 1'b0;
        endcase
    end

endmodule

//--- hdl/reg_file.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32 integer register file.
// Two asynchronous read ports, one write port, x0 reads zero.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    we,
    input  rv_decode_pkg::reg_idx_t wr_idx,
    input  rv_decode_pkg::word_t    wdata,
    input  rv_decode_pkg::reg_idx_t rs1_idx,
    input  rv_decode_pkg::reg_idx_t rs2_idx,
    output rv_decode_pkg::word_t    rs1_val,
    output rv_decode_pkg::word_t    rs2_val
);

    // Storage for x1 to x31.
    rv_decode_pkg::word_t storage [31:1];

    // Write enable as seen by storage.
    logic wr_en;

    assign wr_en = we && (wr_idx != '0);

    // Reads see the array contents directly.
    assign rs1_val = (rs1_idx == '0) ? '0 : storage[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : storage[rs2_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                storage[i] <= '0;
            end
        end else if (wr_en) begin
            storage[wr_idx] <= wdata;
        end
    end

    // x0 never gets written.
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wr_idx != '0);

    // A write shows up on a read of the same index after the edge.
    assert property (@(posedge clk) disable iff (rst)
        wr_en && rs1_idx == wr_idx |=> rs1_idx != $past(wr_idx) || rs1_val == $past(wdata));

endmodule

//--- hdl/if_id_barrier.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stallable pipeline register between fetch and decode.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module if_id_barrier (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  d_valid,
    input  rv_decode_pkg::pc_t    d_pc,
    input  rv_decode_pkg::insn_t  d_insn,
    input  logic                  d_trap,
    input  rv_decode_pkg::cause_t d_cause,
    fetch_bundle_if.barrier       out
);

    // Control bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
            out.trap  <= 1'b0;
        end else if (!stall) begin
            out.valid <= d_valid;
            out.trap  <= d_trap;
        end
    end

    // Payload, only meaningful while valid or trap is set.
    always_ff @(posedge clk) begin
        if (!stall) begin
            out.pc    <= d_pc;
            out.insn  <= d_insn;
            out.cause <= d_cause;
        end
    end

    // A stalled stage keeps its instruction across the edge.
    assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(out.pc) && $stable(out.insn));

endmodule

//--- hdl/fetch_bundle_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered fetch result, carried from the IF/ID barrier
// to the decode logic.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface fetch_bundle_if;

    logic                  valid;
    rv_decode_pkg::pc_t    pc;
    rv_decode_pkg::insn_t  insn;
    logic                  trap;
    rv_decode_pkg::cause_t cause;

    // Register side.
    modport barrier (
        output valid, pc, insn, trap, cause
    );

    // Decode side.
    modport decode (
        input valid, pc, insn, trap, cause
    );

endinterface

//--- hdl/rv_decode_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the RV32 instruction-decode stage.
// Data and address widths, major opcodes, funct3 codes,
// trap causes and the fixed MRET encoding.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_decode_pkg;

    // Data path width.
    localparam int XLEN = 32;

    // Register value.
    typedef logic [XLEN-1:0] word_t;

    // Instruction word.
    typedef logic [31:0] insn_t;

    // Halfword-aligned address, bit 0 is implied zero.
    typedef logic [31:1] pc_t;

    // Register index.
    typedef logic [4:0] reg_idx_t;

    // Trap cause code.
    typedef logic [3:0] cause_t;

    // Major opcode, instruction bits 6 to 2.
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_t;

    // ALU funct3 codes.
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SRL = 3'b101;

    // Illegal instruction trap cause.
    localparam cause_t CAUSE_ILLEGAL_INSN = 4'd2;

    // MRET, the only return instruction in machine mode.
    localparam insn_t INSN_MRET = 32'h3020_0073;

endpackage
